// File: source/mem_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Geometry of the 4 KiB scratchpad and the AXI4-Lite response codes
// Widths below are derived, so only the base values should be edited
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package mem_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Data word
  ////////////////////////////////////////////////////////////////////////////

  localparam int data_size  = 2;                // log2 of bytes per word
  localparam int data_bytes = 1 << data_size;   // Bytes per word
  localparam int data_width = 8 * data_bytes;   // Bits per word

  ////////////////////////////////////////////////////////////////////////////
  // Addressing
  ////////////////////////////////////////////////////////////////////////////

  localparam int axi_addr_width  = 16;                  // Bus address bits
  localparam int bank_count      = 4;                   // Banks behind the decoder
  localparam int bank_sel_width  = $clog2(bank_count);  // Bank select bits
  localparam int bank_addr_width = 10;                  // 1 KiB per bank

  // Whole memory byte address, 4 KiB
  localparam int mem_addr_width = bank_addr_width + bank_sel_width;

  ////////////////////////////////////////////////////////////////////////////
  // Response codes
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [1:0] resp_okay   = 2'b00;  // Normal access
  localparam logic [1:0] resp_decerr = 2'b11;  // No slave at this address

endpackage

`default_nettype wire

// File: source/mem_core.sv
////////////////////////////////////////////////////////////////////////////
// Single port storage column, write on rising edge, read is combinational
// Array has no reset and no initial contents
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mem_core #(
  parameter int elem_width = 8,  // Bits per element
  parameter int addr_width = 8   // Element address bits
) (
  input  logic                  clk_i,    // Write clock
  input  logic                  we_i,     // Write enable for this column
  input  logic [addr_width-1:0] addr_i,   // Element address
  input  logic [elem_width-1:0] wdata_i,  // Element to store
  output logic [elem_width-1:0] rdata_o   // Addressed element
);

  localparam int depth = 2 ** addr_width;  // Elements in the column

  // Storage
  logic [elem_width-1:0] mem_q [depth];

  ////////////////////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[addr_i] <= wdata_i;  // Same edge as the bus handshake
    end
  end

  // Asynchronous read straight from the array
  assign rdata_o = mem_q[addr_i];

endmodule

`default_nettype wire

// File: source/mem_bank.sv
////////////////////////////////////////////////////////////////////////////
// Word wide bank of byte columns, whole aligned words only
// Low data_size address bits are ignored, byte strobes gate each lane
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mem_bank #(
  parameter int addr_width = mem_pkg::bank_addr_width  // Byte address bits of the bank
) (
  input  logic                            clk_i,    // Write clock
  input  logic                            cs_i,     // Write select for the bank
  input  logic [addr_width-1:0]           addr_i,   // Byte address
  input  logic [mem_pkg::data_width-1:0]  wdata_i,  // Write word
  input  logic [mem_pkg::data_bytes-1:0]  wstrb_i,  // Byte lane strobes
  output logic [mem_pkg::data_width-1:0]  rdata_o   // Read word
);

  import mem_pkg::*;

  localparam int word_addr_width = addr_width - data_size;  // Column address bits

  ////////////////////////////////////////////////////////////////////////////
  // Lane write enables
  ////////////////////////////////////////////////////////////////////////////

  logic [data_bytes-1:0] lane_we;    // One enable per byte column
  logic [word_addr_width-1:0] word_addr;  // Aligned word index

  assign word_addr = addr_i[addr_width-1:data_size];  // Drop byte offset

  for (genvar i = 0; i < data_bytes; i++) begin : g_lane_we
    assign lane_we[i] = cs_i & wstrb_i[i];  // Strobed lanes only
  end

  ////////////////////////////////////////////////////////////////////////////
  // Byte columns
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < data_bytes; i++) begin : g_lanes
    mem_core #(
      .elem_width (8),
      .addr_width (word_addr_width)
    ) u_core (
      .clk_i   (clk_i),
      .we_i    (lane_we[i]),
      .addr_i  (word_addr),
      .wdata_i (wdata_i[8*i +: 8]),   // Lane i of the word
      .rdata_o (rdata_o[8*i +: 8])
    );
  end

endmodule

`default_nettype wire

// File: source/mem_array.sv
////////////////////////////////////////////////////////////////////////////
// Four banks behind an address decoder, upper bits pick the bank
// Read data is combinational from the selected bank in the same cycle
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mem_array (
  input  logic                              clk_i,    // Write clock
  input  logic                              cs_i,     // Access strobe
  input  logic                              we_i,     // High for a write
  input  logic [mem_pkg::mem_addr_width-1:0] addr_i,  // In-range byte address
  input  logic [mem_pkg::data_width-1:0]    wdata_i,  // Write word
  input  logic [mem_pkg::data_bytes-1:0]    wstrb_i,  // Byte lane strobes
  output logic [mem_pkg::data_width-1:0]    rdata_o   // Read word
);

  import mem_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////

  logic [bank_sel_width-1:0]  bank_sel;   // Which bank is addressed
  logic [bank_addr_width-1:0] bank_addr;  // Byte address inside the bank
  logic [bank_count-1:0]      bank_cs;    // One-hot write select
  logic                       wr_access;  // Qualified write

  // Bank rdata, one word per bank
  logic [data_width-1:0] bank_rdata [bank_count];

  assign bank_sel  = addr_i[mem_addr_width-1 -: bank_sel_width];  // Top bits
  assign bank_addr = addr_i[bank_addr_width-1:0];
  assign wr_access = cs_i & we_i;  // Reads need no select

  for (genvar b = 0; b < bank_count; b++) begin : g_cs
    assign bank_cs[b] = wr_access & (bank_sel == bank_sel_width'(b));
  end

  ////////////////////////////////////////////////////////////////////////////
  // Banks
  ////////////////////////////////////////////////////////////////////////////

  for (genvar b = 0; b < bank_count; b++) begin : g_banks
    mem_bank #(
      .addr_width (bank_addr_width)
    ) u_bank (
      .clk_i   (clk_i),
      .cs_i    (bank_cs[b]),
      .addr_i  (bank_addr),      // Broadcast
      .wdata_i (wdata_i),        // Broadcast
      .wstrb_i (wstrb_i),        // Broadcast
      .rdata_o (bank_rdata[b])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////////////////////

  // Every bank reads at bank_addr, only the selected word is passed on
  assign rdata_o = bank_rdata[bank_sel];

endmodule

`default_nettype wire

// File: source/axil_mem_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// AXI4-Lite slave for the scratchpad with one write and one read in flight
// AW and W are taken together in one cycle without bursts or AxPROT
// Addresses from 4 KiB up answer DECERR
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module axil_mem_ctrl (
  input  logic                               clk_i,        // Bus clock
  input  logic                               rst_n_i,      // Async active-low reset

  // Write address channel
  input  logic [mem_pkg::axi_addr_width-1:0] awaddr_i,
  input  logic                               awvalid_i,
  output logic                               awready_o,

  // Write data channel
  input  logic [mem_pkg::data_width-1:0]     wdata_i,
  input  logic [mem_pkg::data_bytes-1:0]     wstrb_i,
  input  logic                               wvalid_i,
  output logic                               wready_o,

  // Write response channel
  output logic [1:0]                         bresp_o,
  output logic                               bvalid_o,
  input  logic                               bready_i,

  // Read address channel
  input  logic [mem_pkg::axi_addr_width-1:0] araddr_i,
  input  logic                               arvalid_i,
  output logic                               arready_o,

  // Read data channel
  output logic [mem_pkg::data_width-1:0]     rdata_o,
  output logic [1:0]                         rresp_o,
  output logic                               rvalid_o,
  input  logic                               rready_i,

  // Memory side
  output logic                               mem_cs_o,     // Access strobe
  output logic                               mem_we_o,     // High for a write
  output logic [mem_pkg::mem_addr_width-1:0] mem_addr_o,   // In-range byte address
  output logic [mem_pkg::data_width-1:0]     mem_wdata_o,
  output logic [mem_pkg::data_bytes-1:0]     mem_wstrb_o,
  input  logic [mem_pkg::data_width-1:0]     mem_rdata_i   // Same cycle read data
);

  import mem_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  logic wr_elig;      // Write pair present and B slot free
  logic rd_elig;      // Read present and R slot free
  logic wr_grant;     // Write accepted this cycle
  logic rd_grant;     // Read accepted this cycle
  logic wr_in_range;  // awaddr below 4 KiB
  logic rd_in_range;  // araddr below 4 KiB
  logic prio_rd_q;    // Read wins the next tie

  logic                  bvalid_q;
  logic [1:0]            bresp_q;
  logic                  rvalid_q;
  logic [1:0]            rresp_q;
  logic [data_width-1:0] rdata_q;

  ////////////////////////////////////////////////////////////////////////////
  // Eligibility and arbitration
  ////////////////////////////////////////////////////////////////////////////

  // A held response blocks its own channel only
  assign wr_elig = awvalid_i & wvalid_i & ~bvalid_q;
  assign rd_elig = arvalid_i & ~rvalid_q;

  // Tie goes to the side named by the toggle
  assign wr_grant = wr_elig & (~rd_elig | ~prio_rd_q);
  assign rd_grant = rd_elig & (~wr_elig |  prio_rd_q);

  // Ready only in the accepting cycle
  assign awready_o = wr_grant;
  assign wready_o  = wr_grant;  // Paired with AW
  assign arready_o = rd_grant;

  ////////////////////////////////////////////////////////////////////////////
  // Range check and memory request
  ////////////////////////////////////////////////////////////////////////////

  // In range when nothing is set above the memory address bits
  assign wr_in_range = ~|awaddr_i[axi_addr_width-1:mem_addr_width];
  assign rd_in_range = ~|araddr_i[axi_addr_width-1:mem_addr_width];

  // Out-of-range accesses never strobe the array
  assign mem_cs_o    = (wr_grant & wr_in_range) | (rd_grant & rd_in_range);
  assign mem_we_o    = wr_grant;
  assign mem_addr_o  = wr_grant ? awaddr_i[mem_addr_width-1:0]
                                : araddr_i[mem_addr_width-1:0];
  assign mem_wdata_o = wdata_i;
  assign mem_wstrb_o = wstrb_i;  // Array ignores it on reads

  ////////////////////////////////////////////////////////////////////////////
  // Control registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bvalid_q  <= 1'b0;
      rvalid_q  <= 1'b0;
      prio_rd_q <= 1'b0;  // Write wins the first tie
    end else begin
      if (wr_grant) begin
        bvalid_q <= 1'b1;  // Response one cycle after handshake
      end else if (bready_i) begin
        bvalid_q <= 1'b0;
      end

      if (rd_grant) begin
        rvalid_q <= 1'b1;
      end else if (rready_i) begin
        rvalid_q <= 1'b0;
      end

      if (wr_elig && rd_elig) begin
        prio_rd_q <= ~prio_rd_q;  // Flip only on a real conflict
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response payload
  ////////////////////////////////////////////////////////////////////////////

  // Loaded at the handshake and held until the response is taken
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bresp_q <= resp_okay;
      rresp_q <= resp_okay;
      rdata_q <= '0;
    end else begin
      if (wr_grant) begin
        bresp_q <= wr_in_range ? resp_okay : resp_decerr;
      end
      if (rd_grant) begin
        rresp_q <= rd_in_range ? resp_okay : resp_decerr;
        rdata_q <= rd_in_range ? mem_rdata_i : '0;  // Zero on DECERR
      end
    end
  end

  assign bvalid_o = bvalid_q;
  assign bresp_o  = bresp_q;
  assign rvalid_o = rvalid_q;
  assign rresp_o  = rresp_q;
  assign rdata_o  = rdata_q;

endmodule

`default_nettype wire

// File: source/axil_mem_top.sv
////////////////////////////////////////////////////////////////////////////
// 4 KiB AXI4-Lite scratchpad, controller in front of the bank array
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module axil_mem_top (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic [mem_pkg::axi_addr_width-1:0] awaddr_i,
  input  logic                               awvalid_i,
  output logic                               awready_o,
  input  logic [mem_pkg::data_width-1:0]     wdata_i,
  input  logic [mem_pkg::data_bytes-1:0]     wstrb_i,
  input  logic                               wvalid_i,
  output logic                               wready_o,
  output logic [1:0]                         bresp_o,
  output logic                               bvalid_o,
  input  logic                               bready_i,
  input  logic [mem_pkg::axi_addr_width-1:0] araddr_i,
  input  logic                               arvalid_i,
  output logic                               arready_o,
  output logic [mem_pkg::data_width-1:0]     rdata_o,
  output logic [1:0]                         rresp_o,
  output logic                               rvalid_o,
  input  logic                               rready_i
);

  import mem_pkg::*;

  // Controller to array
  logic                      mem_cs;
  logic                      mem_we;
  logic [mem_addr_width-1:0] mem_addr;
  logic [data_width-1:0]     mem_wdata;
  logic [data_bytes-1:0]     mem_wstrb;
  logic [data_width-1:0]     mem_rdata;   // Combinational return

  axil_mem_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .awaddr_i    (awaddr_i),
    .awvalid_i   (awvalid_i),
    .awready_o   (awready_o),
    .wdata_i     (wdata_i),
    .wstrb_i     (wstrb_i),
    .wvalid_i    (wvalid_i),
    .wready_o    (wready_o),
    .bresp_o     (bresp_o),
    .bvalid_o    (bvalid_o),
    .bready_i    (bready_i),
    .araddr_i    (araddr_i),
    .arvalid_i   (arvalid_i),
    .arready_o   (arready_o),
    .rdata_o     (rdata_o),
    .rresp_o     (rresp_o),
    .rvalid_o    (rvalid_o),
    .rready_i    (rready_i),
    .mem_cs_o    (mem_cs),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_wstrb_o (mem_wstrb),
    .mem_rdata_i (mem_rdata)
  );

  mem_array u_array (
    .clk_i   (clk_i),
    .cs_i    (mem_cs),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .wstrb_i (mem_wstrb),
    .rdata_o (mem_rdata)
  );

endmodule

`default_nettype wire

// File: bench/axil_mem_tb.sv
////////////////////////////////////////////////////////////////////////////
// Directed testbench for the AXI4-Lite scratchpad with one access per channel
// Reads only touch words written earlier since the arrays start undefined
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module axil_mem_tb;

  import mem_pkg::*;

  localparam int mem_bytes  = 1 << mem_addr_width;   // 4 KiB model
  localparam int bank_bytes = 1 << bank_addr_width;  // 1 KiB per bank
  localparam int test_count = 6;
  localparam int rand_ops   = 200;

  logic                      clk_i;
  logic                      rst_n_i;
  logic [axi_addr_width-1:0] awaddr_i;
  logic                      awvalid_i;
  logic                      awready_o;
  logic [data_width-1:0]     wdata_i;
  logic [data_bytes-1:0]     wstrb_i;
  logic                      wvalid_i;
  logic                      wready_o;
  logic [1:0]                bresp_o;
  logic                      bvalid_o;
  logic                      bready_i;
  logic [axi_addr_width-1:0] araddr_i;
  logic                      arvalid_i;
  logic                      arready_o;
  logic [data_width-1:0]     rdata_o;
  logic [1:0]                rresp_o;
  logic                      rvalid_o;
  logic                      rready_i;

  logic [7:0]  model_mem [mem_bytes];  // Reference bytes
  logic [31:0] rng_q;                  // xorshift state
  int          err_cnt;
  int          check_cnt;

  axil_mem_top u_dut (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .awaddr_i  (awaddr_i),
    .awvalid_i (awvalid_i),
    .awready_o (awready_o),
    .wdata_i   (wdata_i),
    .wstrb_i   (wstrb_i),
    .wvalid_i  (wvalid_i),
    .wready_o  (wready_o),
    .bresp_o   (bresp_o),
    .bvalid_o  (bvalid_o),
    .bready_i  (bready_i),
    .araddr_i  (araddr_i),
    .arvalid_i (arvalid_i),
    .arready_o (arready_o),
    .rdata_o   (rdata_o),
    .rresp_o   (rresp_o),
    .rvalid_o  (rvalid_o),
    .rready_i  (rready_i)
  );

  always #2 clk_i = ~clk_i;  // 4 ns period

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic in_range(input logic [axi_addr_width-1:0] addr);
    return int'(addr) < mem_bytes;  // Below 4 KiB
  endfunction

  function automatic logic [1:0] expect_resp(input logic [axi_addr_width-1:0] addr);
    return in_range(addr) ? resp_okay : resp_decerr;
  endfunction

  // Aligned word from the model, zero when out of range
  function automatic logic [data_width-1:0] model_word(input logic [axi_addr_width-1:0] addr);
    logic [data_width-1:0] word;
    int                    base;
    word = '0;
    base = int'(addr) & ~(data_bytes - 1);
    if (in_range(addr)) begin
      for (int b = 0; b < data_bytes; b++) begin
        word[8*b +: 8] = model_mem[base + b];
      end
    end
    return word;
  endfunction

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_q;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_q = x;
    return x;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Bus tasks start and end 0.5 ns after a rising edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic axi_write(input logic [axi_addr_width-1:0] addr,
                           input logic [data_width-1:0] data,
                           input logic [data_bytes-1:0] strb,
                           input logic [1:0] exp_resp, input int hold);
    logic [1:0] seen;
    int         base;
    awaddr_i  = addr;
    awvalid_i = 1'b1;
    wdata_i   = data;
    wstrb_i   = strb;
    wvalid_i  = 1'b1;
    @(negedge clk_i);
    while (!awready_o) begin  // Ready is settled mid cycle
      @(negedge clk_i);
    end
    check_cnt++;
    if (wready_o !== 1'b1 || bvalid_o !== 1'b0) begin
      $display("Fail at %0t: write %h handshake wready %b bvalid %b, expected 1 and 0",
               $time, addr, wready_o, bvalid_o);
      err_cnt++;
    end
    @(posedge clk_i);  // Handshake edge
    #0.5;
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    bready_i  = (hold == 0);
    @(negedge clk_i);
    check_cnt++;
    if (bvalid_o !== 1'b1 || bresp_o !== exp_resp) begin
      $display("Fail at %0t: write %h bvalid %b bresp %0d, expected 1 and %0d",
               $time, addr, bvalid_o, bresp_o, exp_resp);
      err_cnt++;
    end
    seen = bresp_o;
    for (int i = 0; i < hold; i++) begin
      @(posedge clk_i);
      #0.5;
      bready_i = (i == hold - 1);  // Release on the last held cycle
      @(negedge clk_i);
      check_cnt++;
      if (bvalid_o !== 1'b1 || bresp_o !== seen) begin
        $display("Fail at %0t: write response %h changed while bready low", $time, addr);
        err_cnt++;
      end
    end
    @(posedge clk_i);  // B taken here
    #0.5;
    bready_i = 1'b0;
    if (in_range(addr)) begin
      base = int'(addr) & ~(data_bytes - 1);  // Misaligned acts on its word
      for (int b = 0; b < data_bytes; b++) begin
        if (strb[b]) begin
          model_mem[base + b] = data[8*b +: 8];
        end
      end
    end
  endtask

  task automatic axi_read(input logic [axi_addr_width-1:0] addr,
                          input logic [data_width-1:0] exp_data,
                          input logic [1:0] exp_resp, input int hold);
    logic [data_width-1:0] seen_data;
    logic [1:0]            seen_resp;
    araddr_i  = addr;
    arvalid_i = 1'b1;
    @(negedge clk_i);
    while (!arready_o) begin
      @(negedge clk_i);
    end
    check_cnt++;
    if (rvalid_o !== 1'b0) begin
      $display("Fail at %0t: rvalid already high at handshake of read %h", $time, addr);
      err_cnt++;
    end
    @(posedge clk_i);  // Handshake edge
    #0.5;
    arvalid_i = 1'b0;
    rready_i  = (hold == 0);
    @(negedge clk_i);
    check_cnt++;
    if (rvalid_o !== 1'b1) begin
      $display("Fail at %0t: rvalid not high one cycle after read %h", $time, addr);
      err_cnt++;
    end
    check_cnt++;
    if (rdata_o !== exp_data || rresp_o !== exp_resp) begin
      $display("Fail at %0t: read %h gave %h resp %0d, expected %h resp %0d",
               $time, addr, rdata_o, rresp_o, exp_data, exp_resp);
      err_cnt++;
    end
    seen_data = rdata_o;
    seen_resp = rresp_o;
    for (int i = 0; i < hold; i++) begin
      @(posedge clk_i);
      #0.5;
      rready_i = (i == hold - 1);
      @(negedge clk_i);
      check_cnt++;
      if (rvalid_o !== 1'b1 || rdata_o !== seen_data || rresp_o !== seen_resp) begin
        $display("Fail at %0t: read data for %h changed while rready low", $time, addr);
        err_cnt++;
      end
    end
    @(posedge clk_i);  // R taken here
    #0.5;
    rready_i = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic word_readback();
    logic [axi_addr_width-1:0] addr;
    for (int b = 0; b < bank_count; b++) begin
      addr = 16'(b * bank_bytes + 'h10);  // Same offset in every bank
      axi_write(addr, next_rand(), 4'hF, expect_resp(addr), 0);
    end
    for (int b = 0; b < bank_count; b++) begin
      addr = 16'(b * bank_bytes + 'h10);
      axi_read(addr, model_word(addr), resp_okay, 0);
    end
    axi_write(16'(2 * bank_bytes + 'h10), 32'h600DF00D, 4'hF, resp_okay, 0);
    for (int b = 0; b < bank_count; b++) begin
      addr = 16'(b * bank_bytes + 'h10);  // Others keep their words
      axi_read(addr, model_word(addr), resp_okay, 0);
    end
  endtask

  task automatic strobe_merge();
    axi_write(16'h0100, 32'h11223344, 4'hF, resp_okay, 0);
    axi_write(16'h0100, 32'hAABBCCDD, 4'b0101, resp_okay, 0);
    axi_read(16'h0100, 32'h11BB33DD, resp_okay, 0);
    axi_write(16'h0100, 32'h55667788, 4'b1000, resp_okay, 0);
    axi_read(16'h0100, model_word(16'h0100), resp_okay, 0);
    axi_write(16'h0100, 32'hFFFFFFFF, 4'b0000, resp_okay, 0);  // No lanes
    axi_read(16'h0100, 32'h55BB33DD, resp_okay, 0);
  endtask

  task automatic misaligned_access();
    axi_write(16'h0201, 32'hCAFEF00D, 4'hF, resp_okay, 0);  // Lands on 0x200
    axi_read(16'h0200, 32'hCAFEF00D, resp_okay, 0);
    axi_read(16'h0203, 32'hCAFEF00D, resp_okay, 0);
    axi_write(16'h0202, 32'h0000BEEF, 4'b0011, resp_okay, 0);
    axi_read(16'h0201, 32'hCAFEBEEF, resp_okay, 0);
  endtask

  task automatic range_errors();
    axi_write(16'h0300, 32'h0BADCAFE, 4'hF, resp_okay, 0);
    axi_write(16'h1300, 32'hFFFFFFFF, 4'hF, resp_decerr, 0);  // Aliases 0x300
    axi_write(16'hF302, 32'h12345678, 4'hF, resp_decerr, 0);
    axi_read(16'h1300, 32'h0, resp_decerr, 0);
    axi_read(16'hFFFC, 32'h0, resp_decerr, 0);
    axi_read(16'h1000, 32'h0, resp_decerr, 0);
    axi_read(16'h0300, 32'h0BADCAFE, resp_okay, 0);
  endtask

  task automatic stall_and_overlap();
    logic [data_width-1:0] exp;
    axi_write(16'h0500, 32'h01020304, 4'hF, resp_okay, 0);
    axi_write(16'h0600, 32'h05060708, 4'hF, resp_okay, 0);
    exp = model_word(16'h0600);
    fork  // Write wins the first tie
      axi_write(16'h0504, 32'h99AABBCC, 4'hF, resp_okay, 3);
      axi_read(16'h0600, exp, resp_okay, 4);
    join
    exp = model_word(16'h0500);
    fork
      axi_write(16'h0600, 32'hDEAD0000, 4'b1100, resp_okay, 5);
      axi_read(16'h0500, exp, resp_okay, 2);
    join
    fork
      axi_write(16'h1500, 32'h0, 4'hF, resp_decerr, 2);
      axi_read(16'h2600, 32'h0, resp_decerr, 3);
    join
    axi_read(16'h0504, model_word(16'h0504), resp_okay, 0);
    axi_read(16'h0600, model_word(16'h0600), resp_okay, 0);
  endtask

  task automatic random_traffic();
    logic [31:0]               r;
    logic [31:0]               data;
    logic [axi_addr_width-1:0] addr;
    int                        hold;
    // Top 256 bytes filled first so random reads in range hit known words
    for (int w = 0; w < 64; w++) begin
      addr = 16'h0F00 + 16'(4 * w);
      axi_write(addr, next_rand(), 4'hF, resp_okay, 0);
    end
    for (int n = 0; n < rand_ops; n++) begin
      r    = next_rand();
      data = next_rand();
      addr = ((r[3:2] == 2'b11) ? 16'h1000 : 16'h0F00) + 16'(r[15:8]);  // 1 in 4 out
      hold = r[20] ? 1 : 0;
      if (r[4]) begin
        axi_write(addr, data, r[19:16], expect_resp(addr), hold);
      end else begin
        axi_read(addr, model_word(addr), expect_resp(addr), hold);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    awaddr_i = '0;
    awvalid_i = 1'b0;
    wdata_i = '0;
    wstrb_i = '0;
    wvalid_i = 1'b0;
    bready_i = 1'b0;
    araddr_i = '0;
    arvalid_i = 1'b0;
    rready_i = 1'b0;
    rng_q = 32'hde68ac60;
    err_cnt = 0;
    check_cnt = 0;
    repeat (4) @(posedge clk_i);  // Reset for 4 cycles
    #0.5;
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_cnt++;
    if (bvalid_o !== 1'b0 || rvalid_o !== 1'b0 || awready_o !== 1'b0 ||
        wready_o !== 1'b0 || arready_o !== 1'b0) begin
      $display("Fail at %0t: handshake outputs not low after reset", $time);
      err_cnt++;
    end
    @(posedge clk_i);
    #0.5;
    word_readback();
    strobe_merge();
    misaligned_access();
    range_errors();
    stall_and_overlap();
    random_traffic();
    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    repeat (test_count * 200) @(posedge clk_i);  // 200 cycles per test
    $display("Timeout: tests still running after %0d cycles", test_count * 200);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
source/mem_pkg.sv
source/mem_core.sv
source/mem_bank.sv
source/mem_array.sv
source/axil_mem_ctrl.sv
source/axil_mem_top.sv
bench/axil_mem_tb.sv
